//--- include/edp_params.svh
`ifndef EDP_PARAMS_SVH
`define EDP_PARAMS_SVH

// Word geometry, PDP-10 bit numbering 0 (MSB) to 35
`define WORD_BITS 36
`define HALF_BITS 18

// Extra sign bits carried above AD bit 0
`define AD_EXT_BITS 2

// Accumulator fast memory, eight blocks of sixteen
`define FM_DEPTH 128
`define FM_ADDR_BITS 7

`endif

//--- src/eboxPkg.sv
`default_nettype none
`include "edp_params.svh"

package eboxPkg;

  typedef struct packed {
    logic [0:`HALF_BITS-1] left;
    logic [0:`HALF_BITS-1] right;
  } halfWords;

  // AR and the fast memory are written by halves, the ALU sees whole words
  typedef union packed {
    logic [0:`WORD_BITS-1] full;
    halfWords              half;
  } pdp10Word;

  typedef enum logic [1:0] {adaAR, adaARX, adaMQ, adaPC} adaSelT;
  typedef enum logic [1:0] {adbFM, adbBRx2, adbBR, adbARx4} adbSelT;
  typedef enum logic [2:0] {
    adAdd, adSub, adAnd, adOr, adXor, adPassA, adPassB, adZero
  } adFuncT;

  // Code 3 reads EBUS on AR; ARX substitutes MQ there
  typedef enum logic [2:0] {
    arsZero, arsCache, arsAD, arsEbus, arsShift, arsADshl, arsADX, arsMQ
  } arSrc;

  typedef enum logic [1:0] {mqLoad, mqShl, mqShr, mqHold} mqFuncT;
  typedef enum logic [1:0] {mqmADXshr, mqmShift, mqmAD, mqmOnes} mqSrcT;
  typedef enum logic [2:0] {
    dgAR, dgBR, dgMQ, dgFM, dgBRX, dgARX, dgADX, dgAD
  } diagSelT;

  typedef struct packed {
    adaSelT                   adaSel;
    logic                     adaEnable;
    adbSelT                   adbSel;
    adFuncT                   adFunc;
    logic                     carryIn;
    logic                     longOp;
    arSrc                     arlSrc;
    arSrc                     arrSrc;
    logic                     arLoadL;
    logic                     arLoadR;
    logic                     arClearL;
    logic                     arClearR;
    arSrc                     arxlSrc;
    arSrc                     arxrSrc;
    logic                     arxLoad;
    mqFuncT                   mqFunc;
    mqSrcT                    mqSrc;
    logic                     brLoad;
    logic                     brxLoad;
    logic [0:5]               magic;
    logic [`FM_ADDR_BITS-1:0] fmAddr;
    logic                     fmWriteL;
    logic                     fmWriteR;
    diagSelT                  diagSel;
    logic                     diagRead;
    logic                     adToEbusL;
    logic                     adToEbusR;
  } microWord;

  typedef struct packed {
    logic [-`AD_EXT_BITS:`WORD_BITS-1] ad;
    logic [0:`WORD_BITS-1]             adx;
    logic                              carryOut;
    logic                              adxCarryOut;
    logic                              overflow;
  } adResult;

  typedef struct packed {
    pdp10Word ar;
    pdp10Word arx;
    pdp10Word br;
    pdp10Word brx;
    pdp10Word mq;
  } edpView;

  typedef struct packed {
    logic     driving;
    pdp10Word data;
  } ebusDrive;

endpackage

`default_nettype wire

//--- src/operandMux.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module operandMux import eboxPkg::*; (
  input  microWord                          uword,
  input  edpView                            regs,
  input  pdp10Word                          fmData,
  input  pdp10Word                          pcWord,
  output logic [-`AD_EXT_BITS:`WORD_BITS-1] adA,
  output logic [-`AD_EXT_BITS:`WORD_BITS-1] adB,
  output pdp10Word                          adxA,
  output pdp10Word                          adxB
);

  pdp10Word adaWord;

  // ADA is forced to zero unless enabled
  always_comb begin
    if (uword.adaEnable) begin
      unique case (uword.adaSel)
        adaAR:  adaWord = regs.ar;
        adaARX: adaWord = regs.arx;
        adaMQ:  adaWord = regs.mq;
        adaPC:  adaWord = pcWord;
      endcase
    end else begin
      adaWord = '0;
    end
  end

  // Sign extend into bits -2 and -1
  assign adA = {{`AD_EXT_BITS{adaWord.full[0]}}, adaWord.full};

  // ADXA only carries ARX while ADA is idle
  assign adxA = uword.adaEnable ? '0 : regs.arx;

  // Shifted views pull their low bits from the X register of the pair
  always_comb begin
    unique case (uword.adbSel)
      adbFM: begin
        adB = {{`AD_EXT_BITS{fmData.full[0]}}, fmData.full};
        // Magic number lands in the top of ADXB
        adxB.full = {uword.magic, {(`WORD_BITS - $bits(uword.magic)){1'b0}}};
      end
      adbBRx2: begin
        adB = {{`AD_EXT_BITS{regs.br.full[0]}}, regs.br.full[1:`WORD_BITS-1],
               regs.brx.full[0]};
        adxB.full = {regs.brx.full[1:`WORD_BITS-1], 1'b0};
      end
      adbBR: begin
        adB = {{`AD_EXT_BITS{regs.br.full[0]}}, regs.br.full};
        adxB = regs.brx;
      end
      adbARx4: begin
        // AR bits 0 and 1 move up into the extension
        adB = {regs.ar.full, regs.arx.full[0:1]};
        adxB.full = {regs.arx.full[2:`WORD_BITS-1], 2'b00};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/adAlu.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module adAlu import eboxPkg::*; (
  input  logic                              eboxClk,
  input  logic                              reset,
  input  microWord                          uword,
  input  logic [-`AD_EXT_BITS:`WORD_BITS-1] adA,
  input  logic [-`AD_EXT_BITS:`WORD_BITS-1] adB,
  input  pdp10Word                          adxA,
  input  pdp10Word                          adxB,
  output adResult                           alu
);

  localparam int AdBits = `WORD_BITS + `AD_EXT_BITS;

  logic                              isArith;
  logic                              isSub;
  logic                              adCarryIn;
  logic [-`AD_EXT_BITS:`WORD_BITS-1] adBOperand;
  logic [0:`WORD_BITS-1]             adxBOperand;
  logic [AdBits:0]                   adSum;
  logic [`WORD_BITS:0]               adxSum;

  assign isArith = uword.adFunc inside {adAdd, adSub};
  assign isSub = uword.adFunc == adSub;

  // Subtract is A + ~B + carry, the +1 comes in on carryIn
  assign adBOperand = isSub ? ~adB : adB;
  assign adxBOperand = isSub ? ~adxB.full : adxB.full;

  // ADX is the low half of a long operation
  assign adxSum = {1'b0, adxA.full} + {1'b0, adxBOperand}
                + {{`WORD_BITS{1'b0}}, uword.carryIn};

  // Long mode chains the ADX carry into AD
  assign adCarryIn = uword.longOp ? adxSum[`WORD_BITS] : uword.carryIn;

  assign adSum = {1'b0, adA} + {1'b0, adBOperand} + {{AdBits{1'b0}}, adCarryIn};

  always_comb begin
    unique case (uword.adFunc)
      adAdd, adSub: begin
        alu.ad = adSum[AdBits-1:0];
        alu.adx = adxSum[`WORD_BITS-1:0];
      end
      adAnd: begin
        alu.ad = adA & adB;
        alu.adx = adxA.full & adxB.full;
      end
      adOr: begin
        alu.ad = adA | adB;
        alu.adx = adxA.full | adxB.full;
      end
      adXor: begin
        alu.ad = adA ^ adB;
        alu.adx = adxA.full ^ adxB.full;
      end
      adPassA: begin
        alu.ad = adA;
        alu.adx = adxA.full;
      end
      adPassB: begin
        alu.ad = adB;
        alu.adx = adxB.full;
      end
      adZero: begin
        alu.ad = '0;
        alu.adx = '0;
      end
    endcase

    // Boolean functions produce no carries
    alu.carryOut = isArith & adSum[AdBits];
    alu.adxCarryOut = isArith & adxSum[`WORD_BITS];

    // Sign copies in bits -2 and 0 disagree on overflow
    alu.overflow = alu.ad[-`AD_EXT_BITS] ^ alu.ad[0];
  end

  // Microword decode must be clean once out of reset
  adFuncKnown: assert property (@(posedge eboxClk) disable iff (reset)
    !$isunknown(uword.adFunc));

endmodule

`default_nettype wire

//--- src/edpRegisters.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module edpRegisters import eboxPkg::*; (
  input  logic     eboxClk,
  input  logic     reset,
  input  microWord uword,
  input  adResult  alu,
  input  pdp10Word cacheData,
  input  pdp10Word shiftData,
  input  pdp10Word ebusIn,
  output edpView   regs
);

  pdp10Word ar;
  pdp10Word arx;
  pdp10Word br;
  pdp10Word brx;
  pdp10Word mq;
  pdp10Word adWord;
  pdp10Word adShl;
  pdp10Word arlWord;
  pdp10Word arrWord;
  pdp10Word arxlWord;
  pdp10Word arxrWord;
  pdp10Word mqmWord;

  assign adWord.full = alu.ad[0:`WORD_BITS-1];

  // AD times two, ADX bit 0 shifts in
  assign adShl.full = {alu.ad[1:`WORD_BITS-1], alu.adx[0]};

  // Common source decode for the AR and ARX halves
  function automatic pdp10Word pickSource(arSrc sel, logic arxPath);
    pdp10Word w;
    unique case (sel)
      arsZero:  w = '0;
      arsCache: w = cacheData;
      arsAD:    w = adWord;
      arsEbus:  w = arxPath ? mq : ebusIn;
      arsShift: w = shiftData;
      arsADshl: w = adShl;
      arsADX:   w.full = alu.adx;
      arsMQ:    w = mq;
    endcase
    return w;
  endfunction

  always_comb begin
    arlWord = pickSource(uword.arlSrc, 1'b0);
    arrWord = pickSource(uword.arrSrc, 1'b0);
    arxlWord = pickSource(uword.arxlSrc, 1'b1);
    arxrWord = pickSource(uword.arxrSrc, 1'b1);
  end

  // MQM mux
  always_comb begin
    unique case (uword.mqSrc)
      mqmADXshr: mqmWord.full = {alu.adx[`WORD_BITS-2:`WORD_BITS-1],
                                 mq.full[0:`WORD_BITS-3]};
      mqmShift:  mqmWord = shiftData;
      mqmAD:     mqmWord = adWord;
      mqmOnes:   mqmWord.full = '1;
    endcase
  end

  // AR halves, a clear wins over a load
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ar <= '0;
    end else begin
      if (uword.arClearL) begin
        ar.half.left <= '0;
      end else if (uword.arLoadL) begin
        ar.half.left <= arlWord.half.left;
      end
      if (uword.arClearR) begin
        ar.half.right <= '0;
      end else if (uword.arLoadR) begin
        ar.half.right <= arrWord.half.right;
      end
    end
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      arx <= '0;
      br <= '0;
      brx <= '0;
    end else begin
      if (uword.arxLoad) begin
        arx.half.left <= arxlWord.half.left;
        arx.half.right <= arxrWord.half.right;
      end
      if (uword.brLoad) begin
        br <= ar;
      end
      if (uword.brxLoad) begin
        brx <= arx;
      end
    end
  end

  // MQ universal shift register
  always_ff @(posedge eboxClk) begin
    if (reset) begin
      mq <= '0;
    end else begin
      unique case (uword.mqFunc)
        mqLoad: mq <= mqmWord;
        mqShl:  mq.full <= {mq.full[1:`WORD_BITS-1], alu.carryOut};
        mqShr:  mq.full <= {mq.full[0], mq.full[0:`WORD_BITS-2]};
        mqHold: mq <= mq;
      endcase
    end
  end

  assign regs = '{ar: ar, arx: arx, br: br, brx: brx, mq: mq};

  // Loads only from a defined selector
  arlSrcKnown: assert property (@(posedge eboxClk) disable iff (reset)
    (uword.arLoadL && !uword.arClearL) |-> !$isunknown(uword.arlSrc));
  arrSrcKnown: assert property (@(posedge eboxClk) disable iff (reset)
    (uword.arLoadR && !uword.arClearR) |-> !$isunknown(uword.arrSrc));
  arxSrcKnown: assert property (@(posedge eboxClk) disable iff (reset)
    uword.arxLoad |-> !$isunknown({uword.arxlSrc, uword.arxrSrc}));

endmodule

`default_nettype wire

//--- src/fastMem.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module fastMem import eboxPkg::*; (
  input  logic                     eboxClk,
  input  logic [`FM_ADDR_BITS-1:0] fmAddr,
  input  pdp10Word                 wrData,
  input  logic                     writeL,
  input  logic                     writeR,
  output pdp10Word                 rdData
);

  pdp10Word                 mem [`FM_DEPTH];
  logic [`FM_ADDR_BITS-1:0] rdAddr;

  // Halves write independently
  always_ff @(posedge eboxClk) begin
    if (writeL) begin
      mem[fmAddr].half.left <= wrData.half.left;
    end
    if (writeR) begin
      mem[fmAddr].half.right <= wrData.half.right;
    end
    rdAddr <= fmAddr;
  end

  // Read through the registered address
  assign rdData = mem[rdAddr];

  // A write needs a resolved address
  fmAddrKnown: assert property (@(posedge eboxClk)
    (writeL || writeR) |-> !$isunknown(fmAddr));

endmodule

`default_nettype wire

//--- src/ebusDriver.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module ebusDriver import eboxPkg::*; (
  input  logic     eboxClk,
  input  logic     reset,
  input  microWord uword,
  input  edpView   regs,
  input  pdp10Word fmData,
  input  adResult  alu,
  output ebusDrive ebus
);

  logic     adToEbus;
  logic     enableL;
  logic     enableR;
  pdp10Word diagWord;
  ebusDrive nextDrive;

  assign adToEbus = uword.adToEbusL | uword.adToEbusR;
  assign enableL = uword.diagRead | uword.adToEbusL;
  assign enableR = uword.diagRead | uword.adToEbusR;

  // AD takes the bus over any diag select
  always_comb begin
    if (adToEbus) begin
      diagWord.full = alu.ad[0:`WORD_BITS-1];
    end else begin
      unique case (uword.diagSel)
        dgAR:  diagWord = regs.ar;
        dgBR:  diagWord = regs.br;
        dgMQ:  diagWord = regs.mq;
        dgFM:  diagWord = fmData;
        dgBRX: diagWord = regs.brx;
        dgARX: diagWord = regs.arx;
        dgADX: diagWord.full = alu.adx;
        dgAD:  diagWord.full = alu.ad[0:`WORD_BITS-1];
      endcase
    end
  end

  always_comb begin
    nextDrive.driving = enableL | enableR;
    nextDrive.data.half.left = enableL ? diagWord.half.left : '0;
    nextDrive.data.half.right = enableR ? diagWord.half.right : '0;
  end

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      ebus <= '0;
    end else begin
      ebus <= nextDrive;
    end
  end

  // Idle bus must read as zero
  ebusQuiet: assert property (@(posedge eboxClk) disable iff (reset)
    !ebus.driving |-> ebus.data.full == '0);

endmodule

`default_nettype wire

//--- src/edp.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module edp import eboxPkg::*; (
  input  logic     eboxClk,
  input  logic     reset,
  input  microWord uword,
  input  pdp10Word cacheData,
  input  pdp10Word shiftData,
  input  pdp10Word pcWord,
  input  pdp10Word ebusIn,
  output edpView   regs,
  output adResult  alu,
  output pdp10Word fmData,
  output ebusDrive ebus
);

  // ALU operands
  logic [-`AD_EXT_BITS:`WORD_BITS-1] adA;
  logic [-`AD_EXT_BITS:`WORD_BITS-1] adB;
  pdp10Word                          adxA;
  pdp10Word                          adxB;

  operandMux operands (
    .uword  (uword),
    .regs   (regs),
    .fmData (fmData),
    .pcWord (pcWord),
    .adA    (adA),
    .adB    (adB),
    .adxA   (adxA),
    .adxB   (adxB)
  );

  adAlu alu0 (
    .eboxClk (eboxClk),
    .reset   (reset),
    .uword   (uword),
    .adA     (adA),
    .adB     (adB),
    .adxA    (adxA),
    .adxB    (adxB),
    .alu     (alu)
  );

  edpRegisters registers (
    .eboxClk   (eboxClk),
    .reset     (reset),
    .uword     (uword),
    .alu       (alu),
    .cacheData (cacheData),
    .shiftData (shiftData),
    .ebusIn    (ebusIn),
    .regs      (regs)
  );

  // AR is the only write source for the accumulators
  fastMem fm (
    .eboxClk (eboxClk),
    .fmAddr  (uword.fmAddr),
    .wrData  (regs.ar),
    .writeL  (uword.fmWriteL),
    .writeR  (uword.fmWriteR),
    .rdData  (fmData)
  );

  ebusDriver ebusOut (
    .eboxClk (eboxClk),
    .reset   (reset),
    .uword   (uword),
    .regs    (regs),
    .fmData  (fmData),
    .alu     (alu),
    .ebus    (ebus)
  );

endmodule

`default_nettype wire

//--- bench/edpTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "edp_params.svh"

module edpTb import eboxPkg::*; ();

  localparam int ResetCycles = 10;
  localparam int FillCycles = `FM_DEPTH + 2;
  localparam int DirectedCycles = 70;
  localparam int RandomCycles = 2000;
  localparam int CycleLimit = ResetCycles + FillCycles + DirectedCycles + RandomCycles + 100;

  logic     eboxClk = 1'b0;
  logic     reset;
  microWord uword;
  pdp10Word cacheData;
  pdp10Word shiftData;
  pdp10Word pcWord;
  pdp10Word ebusIn;
  edpView   regs;
  adResult  alu;
  pdp10Word fmData;
  ebusDrive ebus;

  // Reference model state
  edpView                   viewModel;
  pdp10Word                 fmModel [`FM_DEPTH];
  logic [`FM_ADDR_BITS-1:0] rdAddrModel;
  ebusDrive                 ebusModel;

  logic        holdReset;
  logic        checking;
  logic        fmKnown;
  logic [31:0] lcgState;
  int          cycleCount = 0;

  edp uut (
    .eboxClk   (eboxClk),
    .reset     (reset),
    .uword     (uword),
    .cacheData (cacheData),
    .shiftData (shiftData),
    .pcWord    (pcWord),
    .ebusIn    (ebusIn),
    .regs      (regs),
    .alu       (alu),
    .fmData    (fmData),
    .ebus      (ebus)
  );

  always #5 eboxClk = ~eboxClk;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic pdp10Word randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    pdp10Word    w;
    hi = nextRandom();
    lo = nextRandom();
    w.full = {hi[3:0], lo};
    return w;
  endfunction

  // Odd multiplier spreads every address bit across the word
  function automatic logic [35:0] fillPattern(input int addr);
    logic [35:0] a;
    a = 36'(addr);
    return (a * 36'h9E3779B97) ^ 36'h5A5A5A5A5;
  endfunction

  function automatic microWord idleWord();
    microWord u;
    u = '0;
    u.mqFunc = mqHold;
    u.adbSel = adbBR;
    u.adFunc = adZero;
    return u;
  endfunction

  // Expected AD/ADX result for the given register state and microword
  function automatic adResult refAlu(input edpView v, input pdp10Word fm, input microWord u,
                                     input pdp10Word pc);
    logic [35:0] aWord;
    logic [37:0] opA;
    logic [37:0] opB;
    logic [35:0] xA;
    logic [35:0] xB;
    logic [71:0] pair;
    logic [38:0] sumAd;
    logic [36:0] sumAdx;
    logic [37:0] adRes;
    logic [35:0] adxRes;
    logic        arith;
    logic        lowCarry;
    adResult     r;
    case (u.adaSel)
      adaAR:  aWord = v.ar.full;
      adaARX: aWord = v.arx.full;
      adaMQ:  aWord = v.mq.full;
      adaPC:  aWord = pc.full;
    endcase
    if (!u.adaEnable) begin
      aWord = '0;
    end
    opA = {{2{aWord[35]}}, aWord};
    xA = u.adaEnable ? 36'd0 : v.arx.full;
    case (u.adbSel)
      adbFM: begin
        opB = {{2{fm.full[0]}}, fm.full};
        xB = {u.magic, 30'd0};
      end
      adbBRx2: begin
        pair = {v.br.full, v.brx.full} << 1;
        opB = {{2{v.br.full[0]}}, pair[71:36]};
        xB = pair[35:0];
      end
      adbBR: begin
        opB = {{2{v.br.full[0]}}, v.br.full};
        xB = v.brx.full;
      end
      adbARx4: begin
        pair = {v.ar.full, v.arx.full};
        opB = pair[71:34];
        xB = {pair[33:0], 2'b00};
      end
    endcase
    arith = (u.adFunc == adAdd) || (u.adFunc == adSub);
    // A minus B as A plus one's complement of B plus carry
    sumAdx = {1'b0, xA} + {1'b0, (u.adFunc == adSub) ? ~xB : xB} + {36'd0, u.carryIn};
    lowCarry = u.longOp ? sumAdx[36] : u.carryIn;
    sumAd = {1'b0, opA} + {1'b0, (u.adFunc == adSub) ? ~opB : opB} + {38'd0, lowCarry};
    case (u.adFunc)
      adAnd: begin
        adRes = opA & opB;
        adxRes = xA & xB;
      end
      adOr: begin
        adRes = opA | opB;
        adxRes = xA | xB;
      end
      adXor: begin
        adRes = opA ^ opB;
        adxRes = xA ^ xB;
      end
      adPassA: begin
        adRes = opA;
        adxRes = xA;
      end
      adPassB: begin
        adRes = opB;
        adxRes = xB;
      end
      adZero: begin
        adRes = '0;
        adxRes = '0;
      end
      default: begin
        adRes = sumAd[37:0];
        adxRes = sumAdx[35:0];
      end
    endcase
    r.ad = adRes;
    r.adx = adxRes;
    r.carryOut = arith & sumAd[38];
    r.adxCarryOut = arith & sumAdx[36];
    r.overflow = adRes[37] ^ adRes[35];
    return r;
  endfunction

  function automatic pdp10Word refSource(input arSrc sel, input logic forArx, input adResult a,
                                         input pdp10Word mqNow);
    logic [37:0] adv;
    pdp10Word    w;
    adv = a.ad;
    case (sel)
      arsZero:  w.full = '0;
      arsCache: w = cacheData;
      arsAD:    w.full = adv[35:0];
      arsEbus:  w = forArx ? mqNow : ebusIn;
      arsShift: w = shiftData;
      arsADshl: w.full = {adv[34:0], a.adx[0]};
      arsADX:   w.full = a.adx;
      arsMQ:    w = mqNow;
    endcase
    return w;
  endfunction

  // One clock edge of the model on the inputs the DUT sampled
  function automatic void modelStep();
    adResult     a;
    edpView      n;
    pdp10Word    fmOld;
    pdp10Word    diag;
    pdp10Word    src;
    logic [35:0] mqv;
    logic [35:0] adxv;
    logic [37:0] adv;
    logic        enL;
    logic        enR;
    fmOld = fmModel[rdAddrModel];
    a = refAlu(viewModel, fmOld, uword, pcWord);
    adv = a.ad;
    adxv = a.adx;
    mqv = viewModel.mq.full;
    n = viewModel;
    if (uword.arClearL) begin
      n.ar.half.left = '0;
    end else if (uword.arLoadL) begin
      src = refSource(uword.arlSrc, 1'b0, a, viewModel.mq);
      n.ar.half.left = src.half.left;
    end
    if (uword.arClearR) begin
      n.ar.half.right = '0;
    end else if (uword.arLoadR) begin
      src = refSource(uword.arrSrc, 1'b0, a, viewModel.mq);
      n.ar.half.right = src.half.right;
    end
    if (uword.arxLoad) begin
      src = refSource(uword.arxlSrc, 1'b1, a, viewModel.mq);
      n.arx.half.left = src.half.left;
      src = refSource(uword.arxrSrc, 1'b1, a, viewModel.mq);
      n.arx.half.right = src.half.right;
    end
    if (uword.brLoad) begin
      n.br = viewModel.ar;
    end
    if (uword.brxLoad) begin
      n.brx = viewModel.arx;
    end
    case (uword.mqFunc)
      mqLoad: begin
        case (uword.mqSrc)
          mqmADXshr: n.mq.full = {adxv[1:0], mqv[35:2]};
          mqmShift:  n.mq = shiftData;
          mqmAD:     n.mq.full = adv[35:0];
          mqmOnes:   n.mq.full = '1;
        endcase
      end
      mqShl:  n.mq.full = {mqv[34:0], a.carryOut};
      mqShr:  n.mq.full = {mqv[35], mqv[35:1]};
      mqHold: n.mq = viewModel.mq;
    endcase

    // AD wins the EBUS when either half asks for it
    enL = uword.diagRead | uword.adToEbusL;
    enR = uword.diagRead | uword.adToEbusR;
    if (uword.adToEbusL || uword.adToEbusR) begin
      diag.full = adv[35:0];
    end else begin
      case (uword.diagSel)
        dgAR:  diag = viewModel.ar;
        dgBR:  diag = viewModel.br;
        dgMQ:  diag = viewModel.mq;
        dgFM:  diag = fmOld;
        dgBRX: diag = viewModel.brx;
        dgARX: diag = viewModel.arx;
        dgADX: diag.full = adxv;
        dgAD:  diag.full = adv[35:0];
      endcase
    end

    // Fast memory ignores reset
    if (uword.fmWriteL) begin
      fmModel[uword.fmAddr].half.left = viewModel.ar.half.left;
    end
    if (uword.fmWriteR) begin
      fmModel[uword.fmAddr].half.right = viewModel.ar.half.right;
    end
    rdAddrModel = uword.fmAddr;

    if (reset) begin
      viewModel = '0;
      ebusModel = '0;
    end else begin
      viewModel = n;
      ebusModel.driving = enL | enR;
      ebusModel.data.half.left = enL ? diag.half.left : '0;
      ebusModel.data.half.right = enR ? diag.half.right : '0;
    end
  endfunction

  task automatic failRun();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input pdp10Word exp, input pdp10Word act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      failRun();
    end
  endtask

  task automatic checkView(input edpView exp, input edpView act);
    checkWord("regs.ar", exp.ar, act.ar);
    checkWord("regs.arx", exp.arx, act.arx);
    checkWord("regs.br", exp.br, act.br);
    checkWord("regs.brx", exp.brx, act.brx);
    checkWord("regs.mq", exp.mq, act.mq);
  endtask

  task automatic checkAlu(input adResult exp, input adResult act);
    if (act !== exp) begin
      $display("[FAIL] %0t alu expected %h got %h", $time, exp, act);
      failRun();
    end
  endtask

  task automatic checkEbus(input ebusDrive exp, input ebusDrive act);
    if (act !== exp) begin
      $display("[FAIL] %0t ebus expected %h got %h", $time, exp, act);
      failRun();
    end
  endtask

  // Outputs are settled mid-cycle
  always @(negedge eboxClk) begin
    if (checking) begin
      checkView(viewModel, regs);
      checkAlu(refAlu(viewModel, fmModel[rdAddrModel], uword, pcWord), alu);
      checkEbus(ebusModel, ebus);
      if (fmKnown) begin
        checkWord("fmData", fmModel[rdAddrModel], fmData);
      end
    end
  end

  always @(posedge eboxClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      failRun();
    end
  end

  task automatic applyCycle(input microWord u, input pdp10Word cache = '0,
                            input pdp10Word shift = '0, input pdp10Word pc = '0,
                            input pdp10Word bus = '0);
    @(posedge eboxClk);
    modelStep();
    reset <= holdReset;
    uword <= u;
    cacheData <= cache;
    shiftData <= shift;
    pcWord <= pc;
    ebusIn <= bus;
  endtask

  task automatic loadWord(input logic [35:0] value, input logic toArx);
    microWord u;
    pdp10Word w;
    u = idleWord();
    if (toArx) begin
      u.arxlSrc = arsCache;
      u.arxrSrc = arsCache;
      u.arxLoad = 1'b1;
    end else begin
      u.arlSrc = arsCache;
      u.arrSrc = arsCache;
      u.arLoadL = 1'b1;
      u.arLoadR = 1'b1;
    end
    w.full = value;
    applyCycle(u, w);
  endtask

  task automatic copyToB();
    microWord u;
    u = idleWord();
    u.brLoad = 1'b1;
    u.brxLoad = 1'b1;
    applyCycle(u);
  endtask

  // AD back into AR, and ADX into ARX when ADA is off
  task automatic aluOp(input adFuncT func, input logic cin, input logic longOp,
                       input logic adaOn, input adbSelT bSel);
    microWord u;
    u = idleWord();
    u.adaEnable = adaOn;
    u.adaSel = adaAR;
    u.adbSel = bSel;
    u.adFunc = func;
    u.carryIn = cin;
    u.longOp = longOp;
    u.arlSrc = arsAD;
    u.arrSrc = arsAD;
    u.arLoadL = 1'b1;
    u.arLoadR = 1'b1;
    u.arxlSrc = arsADX;
    u.arxrSrc = arsADX;
    u.arxLoad = !adaOn;
    applyCycle(u);
    applyCycle(idleWord());
  endtask

  task automatic arithCase(input logic [35:0] a, input logic [35:0] b, input adFuncT func,
                           input logic cin);
    loadWord(b, 1'b0);
    copyToB();
    loadWord(a, 1'b0);
    aluOp(func, cin, 1'b0, 1'b1, adbBR);
  endtask

  initial begin
    microWord    u;
    pdp10Word    w;
    logic [35:0] aVal;
    logic [31:0] hi;
    logic [31:0] lo;
    lcgState = 32'he374c585;
    reset = 1'b1;
    uword = idleWord();
    cacheData = '0;
    shiftData = '0;
    pcWord = '0;
    ebusIn = '0;
    checking = 1'b0;
    fmKnown = 1'b0;
    viewModel = '0;
    ebusModel = '0;
    rdAddrModel = '0;
    for (int i = 0; i < `FM_DEPTH; i++) begin
      fmModel[i] = '0;
    end

    for (int i = 0; i < ResetCycles; i++) begin
      holdReset = (i < ResetCycles - 1);
      applyCycle(idleWord());
    end
    checking = 1'b1;
    @(negedge eboxClk);
    checkView('0, regs);
    checkEbus('0, ebus);

    // Fill every accumulator through AR one word behind the load
    for (int k = 0; k <= `FM_DEPTH; k++) begin
      u = idleWord();
      u.arlSrc = arsCache;
      u.arrSrc = arsCache;
      u.arLoadL = 1'b1;
      u.arLoadR = 1'b1;
      u.fmWriteL = (k > 0);
      u.fmWriteR = (k > 0);
      u.fmAddr = 7'(k - 1);
      w.full = fillPattern(k);
      applyCycle(u, w);
    end
    applyCycle(idleWord());
    fmKnown = 1'b1;

    // Overflow, carry out, subtract and subtract overflow
    arithCase(36'h7FFFFFFFF, 36'h000000001, adAdd, 1'b0);
    arithCase(36'hFFFFFFFFF, 36'h000000001, adAdd, 1'b0);
    arithCase(36'h000000005, 36'h000000007, adSub, 1'b1);
    arithCase(36'h800000000, 36'h000000001, adSub, 1'b1);

    // ADX carry into AD and then the same operands unchained
    loadWord(36'h000000003, 1'b0);
    loadWord(36'h000000001, 1'b1);
    copyToB();
    loadWord(36'hFFFFFFFFF, 1'b1);
    aluOp(adAdd, 1'b0, 1'b1, 1'b0, adbBR);
    loadWord(36'hFFFFFFFFF, 1'b1);
    aluOp(adAdd, 1'b0, 1'b0, 1'b0, adbBR);
    aluOp(adAdd, 1'b0, 1'b0, 1'b1, adbBRx2);
    aluOp(adOr, 1'b0, 1'b0, 1'b1, adbARx4);

    // Left half only into accumulator 5
    aVal = 36'h123456789;
    loadWord(aVal, 1'b0);
    u = idleWord();
    u.fmAddr = 7'd5;
    u.fmWriteL = 1'b1;
    applyCycle(u);
    u.fmWriteL = 1'b0;
    applyCycle(u);
    @(negedge eboxClk);
    w.full = fillPattern(5);
    w.half.left = aVal[35:18];
    checkWord("fmData", w, fmData);
    loadWord(36'h9ABCDEF01, 1'b0);
    u.fmWriteR = 1'b1;
    applyCycle(u);
    u.fmWriteR = 1'b0;
    applyCycle(u);
    aluOp(adAdd, 1'b0, 1'b0, 1'b1, adbFM);

    // MQ load, shifts both ways, hold
    u = idleWord();
    u.mqFunc = mqLoad;
    u.mqSrc = mqmShift;
    applyCycle(u, '0, 36'h80000F0F1);
    u = idleWord();
    u.mqFunc = mqShl;
    u.adaEnable = 1'b1;
    u.adFunc = adSub;
    u.carryIn = 1'b1;
    repeat (3) applyCycle(u);
    u.mqFunc = mqShr;
    repeat (3) applyCycle(u);
    u.mqFunc = mqHold;
    repeat (2) applyCycle(u);
    u.mqFunc = mqLoad;
    u.mqSrc = mqmOnes;
    applyCycle(u);
    u.mqSrc = mqmADXshr;
    applyCycle(u);

    // Every diag source and then AD taking the bus by halves
    u = idleWord();
    u.diagRead = 1'b1;
    for (int s = 0; s < 8; s++) begin
      u.diagSel = diagSelT'(3'(s));
      applyCycle(u);
    end
    u = idleWord();
    u.adaEnable = 1'b1;
    u.adFunc = adPassA;
    u.diagSel = dgMQ;
    u.adToEbusL = 1'b1;
    applyCycle(u);
    u.adToEbusL = 1'b0;
    u.adToEbusR = 1'b1;
    applyCycle(u);
    u.adToEbusL = 1'b1;
    u.diagRead = 1'b1;
    applyCycle(u);
    applyCycle(idleWord());
    applyCycle(idleWord());

    for (int i = 0; i < RandomCycles; i++) begin
      hi = nextRandom();
      lo = nextRandom();
      u = microWord'({hi[$bits(microWord)-33:0], lo});
      applyCycle(u, randomWord(), randomWord(), randomWord(), randomWord());
    end
    applyCycle(idleWord());
    @(posedge eboxClk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
src/eboxPkg.sv
src/operandMux.sv
src/adAlu.sv
src/edpRegisters.sv
src/fastMem.sv
src/ebusDriver.sv
src/edp.sv
bench/edpTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the EDP testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f flist.f --top-module edpTb \
  -Mdir "$buildDir" -o edpSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/edpSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Result: PASSED" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1
